//--- verilog.f
+incdir+verilog
verilog/lc3b_types.sv
verilog/control_rom.sv
verilog/regfile.sv
verilog/alu.sv
verilog/lc3b_datapath.sv
verilog/lc3b_core.sv
sim/tb_clock_gen.sv
sim/lc3b_tb.sv

//--- Bender.yml
package:
  name: lc3b_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lc3b_types.sv
      - verilog/control_rom.sv
      - verilog/regfile.sv
      - verilog/alu.sv
      - verilog/lc3b_datapath.sv
      - verilog/lc3b_core.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tb_clock_gen.sv
      - sim/lc3b_tb.sv

//--- sim/lc3b_tb.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module lc3b_tb
	import lc3b_types::*;
();

localparam lc3b_word data_base = 16'h0100;
localparam int test_timeout = 200;

logic clk, por_n, test_rst_n, arst_n;
lc3b_word imem_addr, imem_rdata, dmem_rdata;
lc3b_dmem_req dmem_req;

logic [7:0] mem [65536];
lc3b_word load_addr;
logic [15:0] lfsr;

// Model state and the data access expected in the current cycle.
lc3b_word m_pc;
lc3b_word m_reg [8];
logic [2:0] m_cc;
logic [7:0] m_mem [65536];
logic exp_read, exp_write;
lc3b_word exp_addr, exp_wdata;
logic [1:0] exp_be;

logic checking;
int errors, checks, tests, test_errors;

assign arst_n = por_n & test_rst_n;

tb_clock_gen u_clock_gen (
	.clk    (clk),
	.arst_n (por_n)
);

lc3b_core u_lc3b_core (
	.clk        (clk),
	.arst_n     (arst_n),
	.imem_addr  (imem_addr),
	.imem_rdata (imem_rdata),
	.dmem_req   (dmem_req),
	.dmem_rdata (dmem_rdata)
);

//////////////////////////////
// Little-endian byte memory. Both ports read the aligned word.
assign imem_rdata = {mem[imem_addr | 16'h1], mem[imem_addr & 16'hfffe]};
assign dmem_rdata = {mem[dmem_req.addr | 16'h1], mem[dmem_req.addr & 16'hfffe]};

always @(posedge clk) begin
	if (arst_n && dmem_req.write) begin
		if (dmem_req.byte_en[0])
			mem[dmem_req.addr & 16'hfffe] <= dmem_req.wdata[7:0];
		if (dmem_req.byte_en[1])
			mem[dmem_req.addr | 16'h1] <= dmem_req.wdata[15:8];
	end
end

// Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1.
// It steps once per bit.
function automatic logic [15:0] rand_bits(int n);
	logic [15:0] v;
	int i;
	v = '0;
	for (i = 0; i < n; i++) begin
		v = {v[14:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
	end
	return v;
endfunction

function automatic lc3b_word sext(lc3b_word v, int n);
	lc3b_word t;
	t = v << (16 - n);
	return lc3b_word'($signed(t) >>> (16 - n));
endfunction

function automatic lc3b_word model_word(lc3b_word addr);
	return {m_mem[addr | 16'h1], m_mem[addr & 16'hfffe]};
endfunction

//////////////////////////////
// ISA reference model that runs one instruction per call.
function automatic void lc3b_step();
	lc3b_word ir, a, b, res, next_pc;
	lc3b_reg dr;
	logic wr_reg;
	int i;
	ir = model_word(m_pc);
	next_pc = m_pc + 16'd2;
	dr = ir[11:9];
	a = m_reg[ir[8:6]];
	b = ir[5] ? sext(ir, 5) : m_reg[ir[2:0]];
	res = '0;
	wr_reg = 1'b1;
	exp_read = 1'b0;
	exp_write = 1'b0;
	exp_addr = '0;
	exp_wdata = '0;
	exp_be = 2'b11;
	case (lc3b_opcode'(ir[15:12]))
		op_add: res = a + b;
		op_and: res = a & b;
		op_not: res = ~a;
		op_shf: begin
			// Shifts one bit position per pass and fills the sign only for SRA.
			res = a;
			for (i = 0; i < ir[3:0]; i++)
				res = ir[4] ? {ir[5] & res[15], res[15:1]} : {res[14:0], 1'b0};
		end
		op_lea: res = next_pc + (sext(ir, 9) << 1);
		op_ldr: begin
			exp_read = 1'b1;
			exp_addr = a + (sext(ir, 6) << 1);
			res = model_word(exp_addr);
		end
		op_ldb: begin
			exp_read = 1'b1;
			exp_addr = a + sext(ir, 6);
			res = sext({8'h00, m_mem[exp_addr]}, 8);
		end
		op_str: begin
			wr_reg = 1'b0;
			exp_write = 1'b1;
			exp_addr = a + (sext(ir, 6) << 1);
			exp_wdata = m_reg[dr];
			m_mem[exp_addr & 16'hfffe] = exp_wdata[7:0];
			m_mem[exp_addr | 16'h1] = exp_wdata[15:8];
		end
		op_stb: begin
			wr_reg = 1'b0;
			exp_write = 1'b1;
			exp_addr = a + sext(ir, 6);
			exp_wdata = {2{m_reg[dr][7:0]}};
			exp_be = exp_addr[0] ? 2'b10 : 2'b01;
			m_mem[exp_addr] = m_reg[dr][7:0];
		end
		op_br: begin
			wr_reg = 1'b0;
			if ((ir[11:9] & m_cc) != 3'b000)
				next_pc = next_pc + (sext(ir, 9) << 1);
		end
		op_jmp: begin
			wr_reg = 1'b0;
			next_pc = a;
		end
		op_jsr: begin
			res = next_pc;
			dr = 3'd7;
			next_pc = ir[11] ? next_pc + (sext(ir, 11) << 1) : a;
		end
		default:
			wr_reg = 1'b0;
	endcase
	if (wr_reg) begin
		m_reg[dr] = res;
		if (ir[15:12] != op_jsr)
			m_cc = res[15] ? 3'b100 : ((res == '0) ? 3'b010 : 3'b001);
	end
	m_pc = next_pc;
endfunction

task automatic check_value(string name, lc3b_word got, lc3b_word exp);
	checks++;
	if (got !== exp) begin
		errors++;
		test_errors++;
		$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
	end
endtask

// Compare with the model in the middle of every cycle.
always @(negedge clk) begin
	if (checking) begin
		check_value("imem_addr", imem_addr, m_pc);
		lc3b_step();
		check_value("dmem_req.read", dmem_req.read, exp_read);
		check_value("dmem_req.write", dmem_req.write, exp_write);
		if (exp_read || exp_write)
			check_value("dmem_req.addr", dmem_req.addr, exp_addr);
		if (exp_write) begin
			check_value("dmem_req.wdata", dmem_req.wdata, exp_wdata);
			check_value("dmem_req.byte_en", dmem_req.byte_en, exp_be);
		end
	end
end

//////////////////////////////
// Program loading.
task automatic put_word(lc3b_word addr, lc3b_word w);
	mem[addr] = w[7:0];
	mem[addr + 16'd1] = w[15:8];
endtask

task automatic emit(lc3b_word w);
	put_word(load_addr, w);
	load_addr = load_addr + 16'd2;
endtask

// Word offset from the instruction at load_addr to target.
function automatic lc3b_word rel(lc3b_word target);
	return (target - load_addr - 16'd2) >> 1;
endfunction

function automatic lc3b_word rri(logic [3:0] op, lc3b_reg r1, lc3b_reg r2, logic [5:0] low);
	return {op, r1, r2, low};
endfunction

function automatic logic [5:0] rand_imm5();
	return 6'h20 | 6'(rand_bits(5));
endfunction

// Holds the core in reset and clears memory.
task automatic begin_load();
	int i;
	@(posedge clk);
	#1;
	checking = 1'b0;
	test_rst_n = 1'b0;
	for (i = 0; i < 65536; i++)
		mem[i] = 8'h00;
	load_addr = `LC3B_RESET_PC;
	test_errors = 0;
	emit({op_lea, 3'd6, 9'(rel(data_base))});
endtask

task automatic run_program(string name);
	lc3b_word end_addr;
	int i;
	int cycles;
	end_addr = load_addr;
	emit({op_br, 3'b111, 9'(rel(load_addr))});
	for (i = 0; i < 65536; i++)
		m_mem[i] = mem[i];
	for (i = 0; i < 8; i++)
		m_reg[i] = '0;
	m_pc = `LC3B_RESET_PC;
	m_cc = 3'b010;
	@(negedge clk);
	check_value("imem_addr", imem_addr, `LC3B_RESET_PC);
	check_value("dmem_req.write", dmem_req.write, 1'b0);
	repeat (2) @(posedge clk);
	#1;
	test_rst_n = 1'b1;
	checking = 1'b1;
	for (cycles = 0; cycles < test_timeout; cycles++) begin
		@(negedge clk);
		if (imem_addr == end_addr)
			break;
	end
	if (cycles == test_timeout) begin
		errors++;
		test_errors++;
		$display("Test %s timed out before the core reached its final loop at %h",
			name, end_addr);
	end
	@(negedge clk);
	#1;
	tests++;
	$display("Test %s: %s, %0d errors", name, (test_errors == 0) ? "passed" : "failed",
		test_errors);
endtask

// Each branch skips one marker store, so exactly one marker is missing.
task automatic branch_ladder(logic [5:0] slot);
	emit({op_br, 3'b100, 9'(rel(load_addr + 16'd4))});
	emit(rri(op_str, 5, 6, slot));
	emit({op_br, 3'b010, 9'(rel(load_addr + 16'd4))});
	emit(rri(op_str, 5, 6, slot + 6'd1));
	emit({op_br, 3'b001, 9'(rel(load_addr + 16'd4))});
	emit(rri(op_str, 5, 6, slot + 6'd2));
endtask

//////////////////////////////
// Tests.
task automatic alu_cc_test();
	begin_load();
	put_word(data_base, rand_bits(16));
	put_word(data_base + 16'd2, rand_bits(16));
	emit(rri(op_ldr, 0, 6, 0));
	emit(rri(op_ldr, 1, 6, 1));
	emit(rri(op_add, 2, 0, 6'd1));
	emit(rri(op_str, 2, 6, 4));
	emit(rri(op_add, 3, 1, rand_imm5()));
	emit(rri(op_str, 3, 6, 5));
	emit(rri(op_and, 2, 0, 6'd1));
	emit(rri(op_str, 2, 6, 6));
	emit(rri(op_and, 3, 0, rand_imm5()));
	emit(rri(op_str, 3, 6, 7));
	emit(rri(op_not, 4, 1, 6'h3f));
	emit(rri(op_str, 4, 6, 8));
	emit(rri(op_add, 5, 0, 6'd1));
	branch_ladder(10);
	emit(rri(op_and, 5, 5, 6'h20));
	branch_ladder(13);
	emit(rri(op_not, 5, 5, 6'h3f));
	branch_ladder(16);
	emit(rri(op_add, 5, 5, 6'h22));
	branch_ladder(19);
	run_program("alu");
endtask

task automatic shift_test();
	begin_load();
	put_word(data_base, rand_bits(16));
	put_word(data_base + 16'd2, rand_bits(16) | 16'h8000);
	emit(rri(op_ldr, 0, 6, 0));
	emit(rri(op_ldr, 1, 6, 1));
	emit(rri(op_shf, 2, 0, {2'b00, 4'(rand_bits(4))}));
	emit(rri(op_str, 2, 6, 4));
	emit(rri(op_shf, 2, 1, {2'b01, 4'(rand_bits(4))}));
	emit(rri(op_str, 2, 6, 5));
	emit(rri(op_shf, 2, 1, {2'b11, 4'(rand_bits(4))}));
	emit(rri(op_str, 2, 6, 6));
	emit(rri(op_shf, 2, 0, {2'b11, 4'(rand_bits(4))}));
	emit(rri(op_str, 2, 6, 7));
	run_program("shift");
endtask

task automatic load_store_test();
	begin_load();
	put_word(data_base, rand_bits(16));
	put_word(data_base + 16'd4, rand_bits(16) | 16'h8080);
	put_word(data_base + 16'd6, rand_bits(16) & 16'h7f7f);
	emit(rri(op_ldr, 0, 6, 0));
	emit(rri(op_str, 0, 6, 10));
	emit(rri(op_ldb, 1, 6, 4));
	emit(rri(op_str, 1, 6, 11));
	emit(rri(op_ldb, 2, 6, 5));
	emit(rri(op_str, 2, 6, 12));
	emit(rri(op_ldb, 3, 6, 6));
	emit(rri(op_str, 3, 6, 13));
	emit(rri(op_ldb, 4, 6, 7));
	emit(rri(op_str, 4, 6, 14));
	// Even and odd byte stores merge into one word that is read back below.
	emit(rri(op_stb, 0, 6, 30));
	emit(rri(op_stb, 1, 6, 31));
	emit(rri(op_ldr, 5, 6, 15));
	emit(rri(op_str, 5, 6, 16));
	run_program("memory");
endtask

task automatic control_flow_test();
	begin_load();
	emit({op_lea, 3'd5, 9'(rel(16'h0040))});
	emit(rri(op_jsr, 0, 5, 0));
	emit({op_jsr, 1'b1, 11'(rel(16'h0050))});
	emit({op_lea, 3'd4, 9'(rel(16'h0030))});
	emit(rri(op_jmp, 0, 4, 0));
	emit(rri(op_add, 0, 0, 6'h21));
	load_addr = 16'h0040;
	emit(rri(op_str, 7, 6, 0));
	emit(rri(op_jmp, 0, 7, 0));
	load_addr = 16'h0050;
	emit(rri(op_str, 7, 6, 1));
	emit(rri(op_jmp, 0, 7, 0));
	load_addr = 16'h0030;
	emit(rri(op_str, 4, 6, 2));
	run_program("control");
endtask

task automatic lea_unimpl_test();
	begin_load();
	emit({op_lea, 3'd1, 9'(rel(16'h0080))});
	emit(rri(op_str, 1, 6, 0));
	emit(rri(op_ldi, 2, 6, 6'(rand_bits(6))));
	emit(rri(op_sti, 1, 6, 6'(rand_bits(6))));
	emit({op_trap, 4'h0, 8'h25});
	emit(rri(op_str, 2, 6, 1));
	// CC still holds the positive LEA result.
	emit({op_br, 3'b001, 9'(rel(load_addr + 16'd4))});
	emit(rri(op_str, 1, 6, 2));
	emit(rri(op_str, 1, 6, 3));
	run_program("lea_unimpl");
endtask

initial begin
	int i;
	test_rst_n = 1'b0;
	checking = 1'b0;
	lfsr = 16'd35;
	errors = 0;
	checks = 0;
	tests = 0;
	test_errors = 0;
	load_addr = '0;
	for (i = 0; i < 65536; i++)
		mem[i] = 8'h00;
	alu_cc_test();
	shift_test();
	load_store_test();
	control_flow_test();
	lea_unimpl_test();
	$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
	if (errors == 0)
		$display("No errors");
	else
		$display("Errors found");
	$finish;
end

endmodule : lc3b_tb

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

// 20 ns clock period.
initial begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

// Power-on reset is released 1 ns after the second rising edge.
initial begin
	arst_n = 1'b0;
	repeat (2) @(posedge clk);
	#1 arst_n = 1'b1;
end

endmodule : tb_clock_gen

//--- verilog/lc3b_core.sv
`timescale 1ns/1ps

module lc3b_core
	import lc3b_types::*;
(
	input logic clk,
	input logic arst_n,
	output lc3b_word imem_addr,
	input lc3b_word imem_rdata,
	output lc3b_dmem_req dmem_req,
	input lc3b_word dmem_rdata
);

lc3b_opcode opcode;
logic A, D, R;
lc3b_control_word ctrl;
logic rf_load;
lc3b_reg rf_dest, rf_src_a, rf_src_b;
lc3b_word rf_in, reg_a, reg_b;
lc3b_word alu_a, alu_b, alu_result;
lc3b_aluop alu_op;

control_rom u_control_rom (
	.opcode (opcode),
	.A      (A),
	.D      (D),
	.R      (R),
	.ctrl   (ctrl)
);

lc3b_datapath u_datapath (
	.clk        (clk),
	.arst_n     (arst_n),
	.imem_addr  (imem_addr),
	.imem_rdata (imem_rdata),
	.opcode     (opcode),
	.A          (A),
	.D          (D),
	.R          (R),
	.ctrl       (ctrl),
	.rf_load    (rf_load),
	.rf_dest    (rf_dest),
	.rf_src_a   (rf_src_a),
	.rf_src_b   (rf_src_b),
	.rf_in      (rf_in),
	.reg_a      (reg_a),
	.reg_b      (reg_b),
	.alu_a      (alu_a),
	.alu_b      (alu_b),
	.alu_op     (alu_op),
	.alu_result (alu_result),
	.dmem_req   (dmem_req),
	.dmem_rdata (dmem_rdata)
);

regfile u_regfile (
	.clk    (clk),
	.arst_n (arst_n),
	.load   (rf_load),
	.dest   (rf_dest),
	.in     (rf_in),
	.src_a  (rf_src_a),
	.src_b  (rf_src_b),
	.reg_a  (reg_a),
	.reg_b  (reg_b)
);

alu u_alu (
	.aluop (alu_op),
	.a     (alu_a),
	.b     (alu_b),
	.f     (alu_result)
);

endmodule : lc3b_core

//--- verilog/lc3b_datapath.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module lc3b_datapath
	import lc3b_types::*;
(
	input logic clk,
	input logic arst_n,
	output lc3b_word imem_addr,
	input lc3b_word imem_rdata,
	output lc3b_opcode opcode,
	output logic A,
	output logic D,
	output logic R,
	input lc3b_control_word ctrl,
	output logic rf_load,
	output lc3b_reg rf_dest,
	output lc3b_reg rf_src_a,
	output lc3b_reg rf_src_b,
	output lc3b_word rf_in,
	input lc3b_word reg_a,
	input lc3b_word reg_b,
	output lc3b_word alu_a,
	output lc3b_word alu_b,
	output lc3b_aluop alu_op,
	input lc3b_word alu_result,
	output lc3b_dmem_req dmem_req,
	input lc3b_word dmem_rdata
);

lc3b_word pc, pc_next, pc_plus2, pc_rel;
lc3b_word ir, sext_out, mem_addr, mem_byte;
logic [2:0] cc, cc_next;
logic br_taken, use_imm;

assign ir = imem_rdata;
assign imem_addr = pc;

// Fields for the decoder.
assign opcode = lc3b_opcode'(ir[15:12]);
assign A = ir[5];
assign D = ir[4];
assign R = ir[11];

//////////////////////////////
// Sign extension and operands.
always_comb begin
	case (ctrl.sext_sel)
		`SEXT_IMM5:  sext_out = {{11{ir[4]}}, ir[4:0]};
		`SEXT_OFF6:  sext_out = {{9{ir[5]}}, ir[5:0], 1'b0};
		`SEXT_OFF9:  sext_out = {{6{ir[8]}}, ir[8:0], 1'b0};
		`SEXT_OFF11: sext_out = {{4{ir[10]}}, ir[10:0], 1'b0};
		`SEXT_BOFF6: sext_out = {{10{ir[5]}}, ir[5:0]};
		default:     sext_out = '0;
	endcase
end

// SHF always takes its amount from the instruction.
assign use_imm = ((ctrl.opcode == op_add || ctrl.opcode == op_and) && ir[5]) ||
		(ctrl.opcode == op_shf);

assign rf_src_a = ir[8:6];
assign rf_src_b = ctrl.src_b_mux_sel ? ir[11:9] : ir[2:0];
assign alu_a = reg_a;
assign alu_b = use_imm ? sext_out : reg_b;
assign alu_op = ctrl.aluop;

//////////////////////////////
// Data port.
assign mem_addr = reg_a + sext_out;
assign mem_byte = mem_addr[0] ? {{8{dmem_rdata[15]}}, dmem_rdata[15:8]} :
		{{8{dmem_rdata[7]}}, dmem_rdata[7:0]};

assign dmem_req.addr = mem_addr;
assign dmem_req.wdata = ctrl.ex_write_sel ? {reg_b[7:0], reg_b[7:0]} : reg_b;
assign dmem_req.read = ctrl.mem_read;
assign dmem_req.write = ctrl.mem_write;
assign dmem_req.byte_en = ctrl.ex_write_sel ? (mem_addr[0] ? 2'b10 : 2'b01) : 2'b11;

//////////////////////////////
// Writeback and condition codes.
assign rf_load = ctrl.load_regfile;
assign rf_dest = ctrl.dest_sel ? 3'd7 : ir[11:9];

always_comb begin
	if (ctrl.lea_mux_sel)
		rf_in = pc_rel;
	else if (ctrl.dest_sel)
		rf_in = pc_plus2;
	else begin
		case (ctrl.wb_sel)
			2'b01: rf_in = dmem_rdata;
			2'b10: rf_in = mem_byte;
			default: rf_in = alu_result;
		endcase
	end
end

always_comb begin
	if (rf_in[15])
		cc_next = 3'b100;
	else if (rf_in == '0)
		cc_next = 3'b010;
	else
		cc_next = 3'b001;
end

//////////////////////////////
// Next PC.
assign pc_plus2 = pc + 16'd2;
assign pc_rel = pc_plus2 + sext_out;
assign br_taken = |(ir[11:9] & cc);

always_comb begin
	case (ctrl.pc_sel)
		2'b01: pc_next = (ctrl.opcode != op_br || br_taken) ? pc_rel : pc_plus2;
		2'b10: pc_next = alu_result;
		default: pc_next = pc_plus2;
	endcase
end

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		pc <= `LC3B_RESET_PC;
		cc <= 3'b010;
	end else begin
		pc <= pc_next;
		if (ctrl.load_cc)
			cc <= cc_next;
	end
end

endmodule : lc3b_datapath

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu
	import lc3b_types::*;
(
	input lc3b_aluop aluop,
	input lc3b_word a,
	input lc3b_word b,
	output lc3b_word f
);

logic [3:0] shamt;

// Shift amount is the low nibble of b.
assign shamt = b[3:0];

always_comb begin
	case (aluop)
		alu_add:
			f = a + b;
		alu_and:
			f = a & b;
		alu_not:
			f = ~a;
		alu_sll:
			f = a << shamt;
		alu_srl:
			f = a >> shamt;
		alu_sra:
			f = lc3b_word'($signed(a) >>> shamt);
		default:
			f = a;
	endcase
end

endmodule : alu

//--- verilog/regfile.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module regfile
	import lc3b_types::*;
(
	input logic clk,
	input logic arst_n,
	input logic load,
	input lc3b_reg dest,
	input lc3b_word in,
	input lc3b_reg src_a,
	input lc3b_reg src_b,
	output lc3b_word reg_a,
	output lc3b_word reg_b
);

lc3b_word data [`LC3B_NUM_REGS];

always_ff @(posedge clk or negedge arst_n) begin
	if (!arst_n) begin
		for (int i = 0; i < `LC3B_NUM_REGS; i++)
			data[i] <= '0;
	end else if (load) begin
		data[dest] <= in;
	end
end

// Reads see the value from before this edge.
assign reg_a = data[src_a];
assign reg_b = data[src_b];

endmodule : regfile

//--- verilog/control_rom.sv
`timescale 1ns/1ps
`include "lc3b_consts.svh"

module control_rom
	import lc3b_types::*;
(
	input lc3b_opcode opcode,
	input logic A,
	input logic D,
	input logic R,
	output lc3b_control_word ctrl
);

always_comb begin
	// Defaults give a no-op that falls through to PC+2.
	ctrl.opcode = opcode;
	ctrl.load_cc = 1'b0;
	ctrl.load_regfile = 1'b0;
	ctrl.pc_sel = 2'b00;
	ctrl.sext_sel = `SEXT_IMM5;
	ctrl.wb_sel = 2'b00;
	ctrl.aluop = alu_add;
	ctrl.src_b_mux_sel = 1'b0;
	ctrl.dest_sel = 1'b0;
	ctrl.ex_write_sel = 1'b0;
	ctrl.lea_mux_sel = 1'b0;
	ctrl.mem_read = 1'b0;
	ctrl.mem_write = 1'b0;

	case (opcode)
		op_add: begin
			ctrl.aluop = alu_add;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_and: begin
			ctrl.aluop = alu_and;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_not: begin
			ctrl.aluop = alu_not;
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
		end
		op_shf: begin
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			if (!D)
				ctrl.aluop = alu_sll;
			else if (!A)
				ctrl.aluop = alu_srl;
			else
				ctrl.aluop = alu_sra;
		end

		//////////////////////////////
		// Control flow.
		op_br: begin
			ctrl.pc_sel = 2'b01;
			ctrl.sext_sel = `SEXT_OFF9;
		end
		op_jmp: begin
			ctrl.aluop = alu_pass;
			ctrl.pc_sel = 2'b10;
		end
		op_jsr: begin
			ctrl.load_regfile = 1'b1;
			ctrl.dest_sel = 1'b1;
			if (R) begin
				ctrl.sext_sel = `SEXT_OFF11;
				ctrl.pc_sel = 2'b01;
			end else begin
				// JSRR jumps through the base register.
				ctrl.aluop = alu_pass;
				ctrl.pc_sel = 2'b10;
			end
		end
		op_lea: begin
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.sext_sel = `SEXT_OFF9;
			ctrl.lea_mux_sel = 1'b1;
		end

		//////////////////////////////
		// Memory access.
		op_ldr: begin
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.wb_sel = 2'b01;
			ctrl.sext_sel = `SEXT_OFF6;
			ctrl.mem_read = 1'b1;
		end
		op_ldb: begin
			ctrl.load_regfile = 1'b1;
			ctrl.load_cc = 1'b1;
			ctrl.wb_sel = 2'b10;
			ctrl.sext_sel = `SEXT_BOFF6;
			ctrl.mem_read = 1'b1;
		end
		op_str: begin
			ctrl.sext_sel = `SEXT_OFF6;
			ctrl.src_b_mux_sel = 1'b1;
			ctrl.mem_write = 1'b1;
		end
		op_stb: begin
			ctrl.sext_sel = `SEXT_BOFF6;
			ctrl.src_b_mux_sel = 1'b1;
			ctrl.ex_write_sel = 1'b1;
			ctrl.mem_write = 1'b1;
		end

		// Not implemented in this core.
		op_ldi: begin
		end
		op_sti: begin
		end
		op_trap: begin
		end
		default: begin
			// RTI and anything else keep the no-op defaults.
		end
	endcase
end

endmodule : control_rom

//--- verilog/lc3b_types.sv
`include "lc3b_consts.svh"

package lc3b_types;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [`LC3B_REG_W-1:0] lc3b_reg;

	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [2:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass,
		alu_sll,
		alu_srl,
		alu_sra
	} lc3b_aluop;

	// Decoded controls for one instruction.
	typedef struct packed {
		lc3b_opcode opcode;
		logic load_cc;
		logic load_regfile;
		logic [1:0] pc_sel;
		logic [2:0] sext_sel;
		logic [1:0] wb_sel;
		lc3b_aluop aluop;
		logic src_b_mux_sel;
		logic dest_sel;
		logic ex_write_sel;
		logic lea_mux_sel;
		logic mem_read;
		logic mem_write;
	} lc3b_control_word;

	// Data-port request that is valid for the cycle it is driven.
	typedef struct packed {
		lc3b_word addr;
		lc3b_word wdata;
		logic read;
		logic write;
		logic [1:0] byte_en;
	} lc3b_dmem_req;

endpackage : lc3b_types

//--- verilog/lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// Datapath widths.
`define LC3B_WORD_W     16
`define LC3B_REG_W      3
`define LC3B_NUM_REGS   8

// First fetch address after reset.
`define LC3B_RESET_PC   16'h0000

// Sign-extension selector codes.
// OFF6, OFF9 and OFF11 are word offsets that are scaled by two.
`define SEXT_IMM5       3'b000
`define SEXT_OFF6       3'b001
`define SEXT_OFF9       3'b010
`define SEXT_BOFF6      3'b100
`define SEXT_OFF11      3'b101

`endif
